//--- rtl/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

`define REN_WIDTH 2   // lanes per cycle
`define COM_WIDTH 2   // commit free ports
`define LREG_NUM  32
`define LREG_W    5
`define PREG_NUM  64
`define PREG_W    6
`define RQ_DEPTH  8   // rename queue entries
`define RQ_W      3
`define BR_SLOTS  4   // branch snapshot slots
`define BR_W      2

`endif

//--- rtl/rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    // small opcode class carried with each renamed entry
    typedef enum logic [2:0] {
        op_nop,
        op_alu,
        op_load,
        op_store,
        op_branch   // only class that takes a snapshot
    } op_class_t;

    typedef logic [`LREG_W-1:0] lreg_t;   // logical register index
    typedef logic [`PREG_W-1:0] preg_t;   // physical register index
    typedef logic [`BR_W-1:0]   brid_t;   // branch snapshot slot

endpackage

//--- rtl/free_list.sv
`timescale 1ns/1ns
`include "rename_cfg.svh"

module free_list
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic  [`REN_WIDTH-1:0] need,       // lane has a nonzero destination
    input  logic  [`REN_WIDTH-1:0] take,       // lanes accepted this cycle
    output logic  [`REN_WIDTH-1:0] grant,      // lane may proceed
    output preg_t [`REN_WIDTH-1:0] preg,
    input  logic  [`COM_WIDTH-1:0] com_free,
    input  preg_t [`COM_WIDTH-1:0] com_preg,
    input  logic  [`REN_WIDTH-1:0] snap,       // accepted branch lanes
    input  brid_t [`REN_WIDTH-1:0] snap_brid,
    input  logic                   redir,
    input  brid_t                  redir_brid
);

    logic [`PREG_NUM-1:0] fl;                        // 1 = free
    logic [`PREG_NUM-1:0] snap_mem [`BR_SLOTS];
    logic [`PREG_NUM-1:0] avail;                     // candidates for the next lane
    logic [`PREG_NUM-1:0] freed;                     // commit returns this cycle
    logic [`REN_WIDTH:0][`PREG_NUM-1:0] fl_step;     // vector after each accepted lane
    logic [`PREG_W:0] hit;                           // {found, index}

    // lowest set bit of the vector
    function automatic logic [`PREG_W:0] first_free(input logic [`PREG_NUM-1:0] v);
        logic [`PREG_W:0] res;
        res = '0;
        for (int b = `PREG_NUM - 1; b >= 0; b--) begin
            if (v[b])
                res = {1'b1, `PREG_W'(b)};
        end
        return res;
    endfunction

    always_comb begin
        avail      = fl;
        avail[0]   = 1'b0;                           // preg 0 is never handed out
        fl_step[0] = fl;
        hit        = '0;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            hit      = first_free(avail);
            grant[i] = ~need[i] | hit[`PREG_W];
            preg[i]  = need[i] ? hit[`PREG_W-1:0] : '0;
            if (need[i])
                avail[preg[i]] = 1'b0;               // later lanes skip it
            fl_step[i+1] = fl_step[i];
            if (take[i] && need[i])
                fl_step[i+1][preg[i]] = 1'b0;
        end
    end

    always_comb begin
        freed = '0;
        for (int c = 0; c < `COM_WIDTH; c++) begin
            if (com_free[c])
                freed[com_preg[c]] = 1'b1;
        end
        freed[0] = 1'b0;                             // preg 0 stays reserved
    end

    // commit frees reach the live list only at the edge, so no same-cycle reuse
    always_ff @(posedge clk) begin
        if (rst)
            fl <= {{(`PREG_NUM - `LREG_NUM){1'b1}}, {`LREG_NUM{1'b0}}};
        else if (redir)
            fl <= snap_mem[redir_brid] | freed;
        else
            fl <= fl_step[`REN_WIDTH] | freed;
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `BR_SLOTS; s++)
            snap_mem[s] <= snap_mem[s] | freed;      // frees survive a later restore
        for (int i = 0; i < `REN_WIDTH; i++) begin
            if (snap[i])
                snap_mem[snap_brid[i]] <= fl_step[i+1] | freed;
        end
    end

    for (genvar i = 0; i < `REN_WIDTH; i++) begin : g_chk
        a_alloc_free: assert property (@(posedge clk) disable iff (rst)
            take[i] && need[i] |-> preg[i] != '0 && fl[preg[i]]);
    end

endmodule

//--- rtl/map_table.sv
`timescale 1ns/1ns
`include "rename_cfg.svh"

module map_table
    import rename_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  lreg_t [`REN_WIDTH-1:0] rs1,
    input  lreg_t [`REN_WIDTH-1:0] rs2,
    input  lreg_t [`REN_WIDTH-1:0] rd,
    output preg_t [`REN_WIDTH-1:0] prs1,
    output preg_t [`REN_WIDTH-1:0] prs2,
    output preg_t [`REN_WIDTH-1:0] old_prd,    // mapping being replaced
    input  logic  [`REN_WIDTH-1:0] wena,       // accepted lanes with rd != 0
    input  preg_t [`REN_WIDTH-1:0] wpreg,
    input  logic  [`REN_WIDTH-1:0] snap,
    input  brid_t [`REN_WIDTH-1:0] snap_brid,
    input  logic                   redir,
    input  brid_t                  redir_brid
);

    preg_t [`LREG_NUM-1:0] mt;
    preg_t [`LREG_NUM-1:0] snap_mem [`BR_SLOTS];
    preg_t [`REN_WIDTH:0][`LREG_NUM-1:0] mt_step;   // table as seen by each lane

    // each lane reads the table with all older lanes' writes applied
    always_comb begin
        mt_step[0] = mt;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            prs1[i]    = mt_step[i][rs1[i]];
            prs2[i]    = mt_step[i][rs2[i]];
            old_prd[i] = mt_step[i][rd[i]];
            mt_step[i+1] = mt_step[i];
            if (wena[i])
                mt_step[i+1][rd[i]] = wpreg[i];
            mt_step[i+1][0] = '0;                   // x0 pinned to preg 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `LREG_NUM; r++)
                mt[r] <= `PREG_W'(r);               // identity map out of reset
        end else if (redir) begin
            mt <= snap_mem[redir_brid];
        end else begin
            mt <= mt_step[`REN_WIDTH];
        end
    end

    // state right after the branch lane, younger lanes excluded
    always_ff @(posedge clk) begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            if (snap[i])
                snap_mem[snap_brid[i]] <= mt_step[i+1];
        end
    end

    // restored snapshots must keep x0 on preg 0 as well
    a_zero_map: assert property (@(posedge clk) disable iff (rst) mt[0] == '0);

endmodule

//--- rtl/rename_queue.sv
`timescale 1ns/1ns
`include "rename_cfg.svh"

module rename_queue
    import rename_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic      [`RQ_W:0]        push_num,
    input  op_class_t [`REN_WIDTH-1:0] w_op,
    input  preg_t     [`REN_WIDTH-1:0] w_prd,
    input  preg_t     [`REN_WIDTH-1:0] w_old_prd,
    input  preg_t     [`REN_WIDTH-1:0] w_prs1,
    input  preg_t     [`REN_WIDTH-1:0] w_prs2,
    input  brid_t     [`REN_WIDTH-1:0] w_brid,
    input  logic      [`RQ_W:0]        pop_num,
    input  logic                       flush,
    output logic      [`RQ_W:0]        count,
    output op_class_t [`REN_WIDTH-1:0] r_op,
    output preg_t     [`REN_WIDTH-1:0] r_prd,
    output preg_t     [`REN_WIDTH-1:0] r_old_prd,
    output preg_t     [`REN_WIDTH-1:0] r_prs1,
    output preg_t     [`REN_WIDTH-1:0] r_prs2,
    output brid_t     [`REN_WIDTH-1:0] r_brid,
    output logic      [`REN_WIDTH-1:0] head_valid
);

    logic [`RQ_W-1:0] front;                    // oldest entry
    logic [`REN_WIDTH-1:0][`RQ_W-1:0] raddr, waddr;
    op_class_t op_mem   [`RQ_DEPTH];
    preg_t     prd_mem  [`RQ_DEPTH];
    preg_t     old_mem  [`RQ_DEPTH];
    preg_t     prs1_mem [`RQ_DEPTH];
    preg_t     prs2_mem [`RQ_DEPTH];
    brid_t     brid_mem [`RQ_DEPTH];

    always_comb begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            raddr[i]      = front + `RQ_W'(i);
            waddr[i]      = raddr[i] + count[`RQ_W-1:0];   // wraps past the tail
            head_valid[i] = int'(count) > i;
            r_op[i]       = op_mem[raddr[i]];
            r_prd[i]      = prd_mem[raddr[i]];
            r_old_prd[i]  = old_mem[raddr[i]];
            r_prs1[i]     = prs1_mem[raddr[i]];
            r_prs2[i]     = prs2_mem[raddr[i]];
            r_brid[i]     = brid_mem[raddr[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            count <= '0;
        end else begin
            front <= front + pop_num[`RQ_W-1:0];
            count <= count + push_num - pop_num;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            if (!flush && i < int'(push_num)) begin
                op_mem[waddr[i]]   <= w_op[i];
                prd_mem[waddr[i]]  <= w_prd[i];
                old_mem[waddr[i]]  <= w_old_prd[i];
                prs1_mem[waddr[i]] <= w_prs1[i];
                prs2_mem[waddr[i]] <= w_prs2[i];
                brid_mem[waddr[i]] <= w_brid[i];
            end
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        count <= `RQ_DEPTH && pop_num <= count);

endmodule

//--- rtl/rename_stage.sv
`timescale 1ns/1ns
`include "rename_cfg.svh"

module rename_stage
    import rename_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic      [`REN_WIDTH-1:0] dec_valid,
    input  op_class_t [`REN_WIDTH-1:0] dec_op,
    input  lreg_t     [`REN_WIDTH-1:0] dec_rd,
    input  lreg_t     [`REN_WIDTH-1:0] dec_rs1,
    input  lreg_t     [`REN_WIDTH-1:0] dec_rs2,
    input  brid_t     [`REN_WIDTH-1:0] dec_brid,
    output logic      [`REN_WIDTH-1:0] ready,
    input  logic      [`REN_WIDTH-1:0] rename,      // consumer pop, in-order prefix
    output logic      [`REN_WIDTH-1:0] ren_valid,
    output op_class_t [`REN_WIDTH-1:0] ren_op,
    output preg_t     [`REN_WIDTH-1:0] ren_prd,
    output preg_t     [`REN_WIDTH-1:0] ren_old_prd,
    output preg_t     [`REN_WIDTH-1:0] ren_prs1,
    output preg_t     [`REN_WIDTH-1:0] ren_prs2,
    output brid_t     [`REN_WIDTH-1:0] ren_brid,
    input  logic      [`COM_WIDTH-1:0] com_free,
    input  preg_t     [`COM_WIDTH-1:0] com_preg,
    input  logic                       redir,
    input  brid_t                      redir_brid
);

    logic  [`REN_WIDTH-1:0] need, grant, take, snap, wena;
    preg_t [`REN_WIDTH-1:0] alloc_preg;              // 0 for lanes with rd == 0
    preg_t [`REN_WIDTH-1:0] map_prs1, map_prs2, map_old_prd;
    logic  [`RQ_W:0] q_count, push_num, pop_num;
    logic in_order, in_pop;

    always_comb begin
        for (int i = 0; i < `REN_WIDTH; i++) begin
            need[i] = dec_rd[i] != '0;
            wena[i] = take[i] & need[i];
            snap[i] = take[i] & (dec_op[i] == op_branch);
        end
    end

    // ready stops at the first lane lacking input, a register or a queue slot
    always_comb begin
        in_order = 1'b1;
        push_num = '0;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            in_order = in_order & dec_valid[i] & grant[i] & (int'(q_count) + i < `RQ_DEPTH);
            ready[i] = in_order;
            take[i]  = in_order & ~redir;            // redirect drops the group
            if (take[i])
                push_num = push_num + 1'b1;
        end
    end

    always_comb begin
        in_pop  = ~redir;
        pop_num = '0;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            in_pop = in_pop & rename[i] & ren_valid[i];
            if (in_pop)
                pop_num = pop_num + 1'b1;
        end
    end

    free_list free_list_inst (
        .clk        (clk),
        .rst        (rst),
        .need       (need),
        .take       (take),
        .grant      (grant),
        .preg       (alloc_preg),
        .com_free   (com_free),
        .com_preg   (com_preg),
        .snap       (snap),
        .snap_brid  (dec_brid),
        .redir      (redir),
        .redir_brid (redir_brid)
    );

    map_table map_table_inst (
        .clk        (clk),
        .rst        (rst),
        .rs1        (dec_rs1),
        .rs2        (dec_rs2),
        .rd         (dec_rd),
        .prs1       (map_prs1),
        .prs2       (map_prs2),
        .old_prd    (map_old_prd),
        .wena       (wena),
        .wpreg      (alloc_preg),
        .snap       (snap),
        .snap_brid  (dec_brid),
        .redir      (redir),
        .redir_brid (redir_brid)
    );

    rename_queue queue_inst (
        .clk        (clk),
        .rst        (rst),
        .push_num   (push_num),
        .w_op       (dec_op),
        .w_prd      (alloc_preg),
        .w_old_prd  (map_old_prd),
        .w_prs1     (map_prs1),
        .w_prs2     (map_prs2),
        .w_brid     (dec_brid),
        .pop_num    (pop_num),
        .flush      (redir),
        .count      (q_count),
        .r_op       (ren_op),
        .r_prd      (ren_prd),
        .r_old_prd  (ren_old_prd),
        .r_prs1     (ren_prs1),
        .r_prs2     (ren_prs2),
        .r_brid     (ren_brid),
        .head_valid (ren_valid)
    );

    a_ready_prefix: assert property (@(posedge clk) disable iff (rst)
        (ready & ~dec_valid) == '0 && (!ready[1] || ready[0]));

endmodule

//--- verification/rename_tb.sv
`timescale 1ns/1ns
`include "rename_cfg.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int RAND_INSTRS  = 200;
    localparam int WATCH_CYCLES = 8 + 400 + RAND_INSTRS * 6;   // reset, directed, random

    typedef struct packed {
        op_class_t op;
        lreg_t     rd;
        lreg_t     rs1;
        lreg_t     rs2;
        brid_t     brid;
    } instr_t;

    typedef struct packed {
        op_class_t op;
        preg_t     prd;
        preg_t     old_prd;
        preg_t     prs1;
        preg_t     prs2;
        brid_t     brid;
    } entry_t;

    logic clk;
    logic rst;
    logic      [`REN_WIDTH-1:0] dec_valid;
    op_class_t [`REN_WIDTH-1:0] dec_op;
    lreg_t     [`REN_WIDTH-1:0] dec_rd;
    lreg_t     [`REN_WIDTH-1:0] dec_rs1;
    lreg_t     [`REN_WIDTH-1:0] dec_rs2;
    brid_t     [`REN_WIDTH-1:0] dec_brid;
    logic      [`REN_WIDTH-1:0] ready;
    logic      [`REN_WIDTH-1:0] rename;
    logic      [`REN_WIDTH-1:0] ren_valid;
    op_class_t [`REN_WIDTH-1:0] ren_op;
    preg_t     [`REN_WIDTH-1:0] ren_prd;
    preg_t     [`REN_WIDTH-1:0] ren_old_prd;
    preg_t     [`REN_WIDTH-1:0] ren_prs1;
    preg_t     [`REN_WIDTH-1:0] ren_prs2;
    brid_t     [`REN_WIDTH-1:0] ren_brid;
    logic      [`COM_WIDTH-1:0] com_free;
    preg_t     [`COM_WIDTH-1:0] com_preg;
    logic                       redir;
    brid_t                      redir_brid;

    preg_t                m_map [`LREG_NUM];          // model map table
    logic [`PREG_NUM-1:0] m_free;                     // model free vector
    preg_t                s_map [`BR_SLOTS][`LREG_NUM];
    logic [`PREG_NUM-1:0] s_free [`BR_SLOTS];
    entry_t exp_q[$];                                 // expected queue contents
    instr_t pend[$];                                  // decoder side, oldest first
    preg_t  com_q[$];                                 // registers to free
    preg_t  dead_q[$];                                // overwritten mappings not freed yet
    logic [31:0] rng;
    int     cons_mode;                                // 0 hold, 1 pop all, 2 random
    logic   auto_commit;
    logic   redir_req;
    brid_t  redir_req_brid;

    rename_stage rename_stage_inst (.*);

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int free_count();
        int n;
        n = 0;
        for (int p = 1; p < `PREG_NUM; p++)
            n = n + int'(m_free[p]);
        return n;
    endfunction

    // lowest free first, x0 on preg 0, older lanes already applied
    function automatic entry_t ref_rename(input instr_t ins);
        entry_t e;
        e.op      = ins.op;
        e.brid    = ins.brid;
        e.prs1    = m_map[ins.rs1];
        e.prs2    = m_map[ins.rs2];
        e.old_prd = m_map[ins.rd];
        e.prd     = '0;
        if (ins.rd != '0) begin
            for (int p = `PREG_NUM - 1; p >= 1; p--) begin
                if (m_free[p])
                    e.prd = preg_t'(p);
            end
            m_free[e.prd]  = 1'b0;
            m_map[ins.rd] = e.prd;
        end
        if (ins.op == op_branch) begin
            for (int r = 0; r < `LREG_NUM; r++)
                s_map[ins.brid][r] = m_map[r];
            s_free[ins.brid] = m_free;
        end
        return e;
    endfunction

    function automatic logic [`REN_WIDTH-1:0] ref_ready();
        logic [`REN_WIDTH-1:0] r;
        logic ok;
        int avail;
        avail = free_count();
        ok    = 1'b1;
        for (int i = 0; i < `REN_WIDTH; i++) begin
            if (dec_rd[i] != '0) begin
                ok    = ok & (avail > 0);
                avail = avail - 1;
            end
            ok   = ok & dec_valid[i] & (exp_q.size() + i < `RQ_DEPTH);
            r[i] = ok;
        end
        return r;
    endfunction

    task automatic abort();
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort();
        end
    endtask

    task automatic push_instr(input op_class_t op, input int rd, input int rs1,
                              input int rs2, input int brid);
        instr_t ins;
        ins.op   = op;
        ins.rd   = lreg_t'(rd);
        ins.rs1  = lreg_t'(rs1);
        ins.rs2  = lreg_t'(rs2);
        ins.brid = brid_t'(brid);
        pend.push_back(ins);
    endtask

    // wait for the model queues to reach the given levels
    task automatic wait_levels(input int want_exp, input int want_pend, input int limit);
        int n;
        n = 0;
        while (exp_q.size() != want_exp || pend.size() != want_pend || com_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                $display("timed out after %0d cycles waiting for %0d queued and %0d pending",
                         limit, want_exp, want_pend);
                abort();
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCH_CYCLES * 4);
        $display("watchdog expired after %0d cycles", WATCH_CYCLES);
        abort();
    end

    // decoder, consumer, commit and redirect drive, 1 ns after the edge
    initial begin
        logic [31:0] r;
        dec_valid  = '0;
        dec_rd     = '0;
        dec_rs1    = '0;
        dec_rs2    = '0;
        dec_brid   = '0;
        for (int i = 0; i < `REN_WIDTH; i++)
            dec_op[i] = op_nop;
        rename     = '0;
        com_free   = '0;
        com_preg   = '0;
        redir      = 1'b0;
        redir_brid = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int i = 0; i < `REN_WIDTH; i++) begin
                dec_valid[i] = pend.size() > i;
                if (pend.size() > i) begin
                    dec_op[i]   = pend[i].op;
                    dec_rd[i]   = pend[i].rd;
                    dec_rs1[i]  = pend[i].rs1;
                    dec_rs2[i]  = pend[i].rs2;
                    dec_brid[i] = pend[i].brid;
                end else begin
                    dec_op[i]   = op_nop;
                    dec_rd[i]   = '0;
                    dec_rs1[i]  = '0;
                    dec_rs2[i]  = '0;
                    dec_brid[i] = '0;
                end
            end
            if (cons_mode == 0) begin
                rename = '0;
            end else if (cons_mode == 1) begin
                rename = '1;
            end else begin
                r         = xorshift();
                rename[0] = r[0] | r[1];
                rename[1] = rename[0] & r[2];       // keep the prefix
            end
            for (int c = 0; c < `COM_WIDTH; c++) begin
                com_free[c] = com_q.size() != 0;
                if (com_q.size() != 0)
                    com_preg[c] = com_q.pop_front();
                else
                    com_preg[c] = '0;
            end
            redir      = redir_req;
            redir_brid = redir_req_brid;
            redir_req  = 1'b0;
        end
    end

    // inputs and outputs are settled mid-cycle
    always @(negedge clk) begin : monitor
        entry_t e;
        instr_t ins;
        logic [`REN_WIDTH-1:0] exp_ready;
        logic popping;
        if (!rst) begin
            exp_ready = ref_ready();
            compare("ready", 32'(ready), 32'(exp_ready));
            for (int i = 0; i < `REN_WIDTH; i++)
                compare($sformatf("ren_valid[%0d]", i), 32'(ren_valid[i]),
                        32'(exp_q.size() > i));
            if (redir) begin
                for (int r = 0; r < `LREG_NUM; r++)
                    m_map[r] = s_map[redir_brid][r];
                m_free = s_free[redir_brid];
                exp_q.delete();                     // group and pops dropped
            end else begin
                popping = 1'b1;
                for (int i = 0; i < `REN_WIDTH; i++) begin
                    popping = popping & rename[i] & ren_valid[i];
                    if (popping) begin
                        e = exp_q.pop_front();
                        compare($sformatf("ren_op[%0d]", i), 32'(ren_op[i]), 32'(e.op));
                        compare($sformatf("ren_prd[%0d]", i), 32'(ren_prd[i]), 32'(e.prd));
                        compare($sformatf("ren_old_prd[%0d]", i), 32'(ren_old_prd[i]),
                                32'(e.old_prd));
                        compare($sformatf("ren_prs1[%0d]", i), 32'(ren_prs1[i]), 32'(e.prs1));
                        compare($sformatf("ren_prs2[%0d]", i), 32'(ren_prs2[i]), 32'(e.prs2));
                        compare($sformatf("ren_brid[%0d]", i), 32'(ren_brid[i]), 32'(e.brid));
                        if (e.old_prd != '0 && auto_commit)
                            com_q.push_back(e.old_prd);
                        else if (e.old_prd != '0)
                            dead_q.push_back(e.old_prd);
                    end
                end
                for (int i = 0; i < `REN_WIDTH; i++) begin
                    if (dec_valid[i] && ready[i]) begin
                        ins.op   = dec_op[i];
                        ins.rd   = dec_rd[i];
                        ins.rs1  = dec_rs1[i];
                        ins.rs2  = dec_rs2[i];
                        ins.brid = dec_brid[i];
                        exp_q.push_back(ref_rename(ins));
                        void'(pend.pop_front());
                    end
                end
            end
            for (int c = 0; c < `COM_WIDTH; c++) begin
                if (com_free[c] && com_preg[c] != '0) begin
                    m_free[com_preg[c]] = 1'b1;
                    for (int s = 0; s < `BR_SLOTS; s++)
                        s_free[s][com_preg[c]] = 1'b1;   // frees outlive a restore
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        int n;
        int lo;
        preg_t late;
        rst            = 1'b1;
        rng            = 32'd68;
        cons_mode      = 0;
        auto_commit    = 1'b0;
        redir_req      = 1'b0;
        redir_req_brid = '0;
        for (int k = 0; k < `LREG_NUM; k++) begin
            m_map[k] = preg_t'(k);
            for (int s = 0; s < `BR_SLOTS; s++)
                s_map[s][k] = preg_t'(k);
        end
        m_free = {{(`PREG_NUM - `LREG_NUM){1'b1}}, {`LREG_NUM{1'b0}}};
        for (int s = 0; s < `BR_SLOTS; s++)
            s_free[s] = m_free;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // identity sources, allocation from 32 upward
        @(posedge clk);
        cons_mode = 1;
        push_instr(op_alu, 1, 2, 3, 0);
        push_instr(op_alu, 4, 5, 6, 0);
        push_instr(op_load, 8, 9, 10, 0);
        push_instr(op_alu, 11, 12, 13, 0);
        wait_levels(0, 0, 40);

        // lane 1 depends on lane 0, then x0 destinations
        push_instr(op_alu, 7, 1, 2, 0);
        push_instr(op_alu, 7, 7, 7, 0);
        wait_levels(0, 0, 20);
        push_instr(op_store, 0, 7, 1, 0);
        push_instr(op_alu, 0, 4, 0, 0);
        push_instr(op_alu, 9, 0, 7, 0);
        wait_levels(0, 0, 20);

        // back-pressure fills the queue
        cons_mode = 0;
        for (int k = 0; k < 10; k++)
            push_instr(op_alu, k + 14, k + 1, k + 2, 0);
        wait_levels(`RQ_DEPTH, 2, 40);
        repeat (4) @(posedge clk);
        cons_mode = 1;
        wait_levels(0, 0, 40);

        // run out of registers, then free some back
        n = free_count();
        for (int k = 0; k < n + 2; k++)
            push_instr(op_alu, 1 + k % 31, k % 32, (k + 5) % 32, 0);
        wait_levels(0, 2, 100);
        repeat (4) @(posedge clk);
        com_q.push_back(dead_q.pop_front());
        wait_levels(0, 1, 20);
        com_q.push_back(dead_q.pop_front());
        com_q.push_back(dead_q.pop_front());
        wait_levels(0, 0, 20);

        // branch snapshot, younger work, a late free, then redirect
        lo = 0;
        for (int k = 1; k < dead_q.size(); k++) begin
            if (dead_q[k] < dead_q[lo])
                lo = k;
        end
        late = dead_q[lo];                          // lowest, first pick after the restore
        dead_q.delete(lo);
        while (dead_q.size() != 0)
            com_q.push_back(dead_q.pop_front());
        wait_levels(0, 0, 40);
        cons_mode = 0;
        push_instr(op_branch, 0, 14, 15, 2);
        push_instr(op_alu, 14, 14, 1, 0);
        push_instr(op_alu, 15, 14, 2, 0);
        wait_levels(3, 0, 20);
        com_q.push_back(late);
        wait_levels(3, 0, 20);
        redir_req_brid = 2'd2;
        redir_req      = 1'b1;
        wait_levels(0, 0, 10);
        cons_mode = 1;
        push_instr(op_alu, 14, 14, 15, 0);
        push_instr(op_alu, 15, 15, 14, 1);
        wait_levels(0, 0, 20);

        // random mix with random consumer and frees on pop
        auto_commit = 1'b1;
        cons_mode   = 2;
        for (int k = 0; k < RAND_INSTRS; k++) begin
            r = xorshift();
            push_instr(op_class_t'(3'(r % 5)), int'(r[8:4]), int'(r[13:9]),
                       int'(r[18:14]), int'(r[20:19]));
        end
        wait_levels(0, 0, RAND_INSTRS * 5);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/rename_queue.sv
rtl/rename_stage.sv
verification/rename_tb.sv

//--- Makefile
SIM      := verilator
TOP      := rename_tb
FILELIST := vlog.f
FLAGS    := --binary --timing --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
HEADERS  := rtl/rename_cfg.svh
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
